// File: hdl/rf_config.svh
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

`define RF_LANES   8   // Lanes per register
`define RF_LANE_W  32
`define RF_BANKS   4   // Bank is register number bits 1:0
`define RF_ROWS    8   // Row is register number bits 4:2
`define RF_NUM_OC  2

`endif

// File: hdl/rf_pkg.sv
`include "rf_config.svh"

package rf_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] row_t;

    typedef logic [`RF_LANES*`RF_LANE_W-1:0] lane_data_t;  // Lane 0 in the low bits
    typedef logic [`RF_LANES-1:0] lane_mask_t;

    // Bit 2*collector+slot set means that operand slot takes the data
    typedef logic [2*`RF_NUM_OC-1:0] oc_tag_t;

    typedef logic [7:0] instr_id_t;

endpackage

// File: hdl/rf_read_if.sv
`include "rf_config.svh"

interface rf_read_if;

    logic [`RF_BANKS-1:0] rd_en;
    rf_pkg::row_t [`RF_BANKS-1:0] rd_row;
    rf_pkg::oc_tag_t [`RF_BANKS-1:0] rd_tag;  // May carry several bits for a merged read

    logic [`RF_BANKS-1:0] rsp_valid;                // One cycle after rd_en
    rf_pkg::oc_tag_t [`RF_BANKS-1:0] rsp_tag;
    rf_pkg::lane_data_t [`RF_BANKS-1:0] rsp_data;

    modport arb (output rd_en, rd_row, rd_tag);

    modport rf (
        input  rd_en, rd_row, rd_tag,
        output rsp_valid, rsp_tag, rsp_data
    );

    modport oc (input rsp_valid, rsp_tag, rsp_data);

endinterface

// File: hdl/masked_bank.sv
`include "rf_config.svh"

module masked_bank (
    input  logic               clk,
    input  rf_pkg::lane_mask_t wr_mask,
    input  rf_pkg::row_t       row,
    input  rf_pkg::lane_data_t wr_data,
    output rf_pkg::lane_data_t rd_data
);

    logic [`RF_LANE_W-1:0] mem [`RF_ROWS][`RF_LANES];

    // Read and write share the row address so a written row reads back its old value
    always_ff @(posedge clk)
    begin
        for (int l = 0; l < `RF_LANES; l++)
        begin
            if (wr_mask[l])
                mem[row][l] <= wr_data[l*`RF_LANE_W +: `RF_LANE_W];
            rd_data[l*`RF_LANE_W +: `RF_LANE_W] <= mem[row][l];
        end
    end

endmodule

// File: hdl/register_file.sv
`include "rf_config.svh"

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_en,
    input  rf_pkg::reg_idx_t   wb_reg,
    input  rf_pkg::lane_mask_t wb_mask,
    input  rf_pkg::lane_data_t wb_data,
    rf_read_if.rf              rd
);

    for (genvar b = 0; b < `RF_BANKS; b++)
    begin : g_bank
        logic               wb_sel;
        rf_pkg::row_t       bank_row;
        rf_pkg::lane_mask_t bank_mask;

        assign wb_sel    = wb_en && (wb_reg[1:0] == 2'(b));
        assign bank_row  = wb_sel ? wb_reg[4:2] : rd.rd_row[b];  // Writeback owns the port
        assign bank_mask = wb_sel ? wb_mask : '0;

        masked_bank u_bank (
            .clk     (clk),
            .wr_mask (bank_mask),
            .row     (bank_row),
            .wr_data (wb_data),
            .rd_data (rd.rsp_data[b])
        );
    end

    // Tags travel alongside the registered bank read
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd.rsp_valid <= '0;
            rd.rsp_tag   <= '0;
        end
        else
        begin
            rd.rsp_valid <= rd.rd_en;
            rd.rsp_tag   <= rd.rd_tag;
        end
    end

endmodule

// File: hdl/bank_arbiter.sv
`include "rf_config.svh"

module bank_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [2*`RF_NUM_OC-1:0]                req,
    input  rf_pkg::reg_idx_t [2*`RF_NUM_OC-1:0]    req_reg,
    input  logic                                   wb_en,
    input  rf_pkg::reg_idx_t                       wb_reg,
    output rf_pkg::oc_tag_t                        grant,
    rf_read_if.arb                                 rd
);

    localparam int PW = $clog2(`RF_NUM_OC);

    logic [PW-1:0] rr_ptr [`RF_BANKS];
    logic [PW-1:0] winner [`RF_BANKS];

    always_comb
    begin
        logic             found;
        logic             en;
        logic [PW-1:0]    win;
        rf_pkg::reg_idx_t sel_reg;
        int               c;

        grant = '0;
        for (int b = 0; b < `RF_BANKS; b++)
        begin
            found   = 1'b0;
            win     = '0;
            sel_reg = '0;
            for (int k = 0; k < `RF_NUM_OC; k++)
            begin
                c = (int'(rr_ptr[b]) + k) % `RF_NUM_OC;
                if (!found && req[2*c] && req_reg[2*c][1:0] == 2'(b))
                begin
                    found   = 1'b1;
                    win     = PW'(c);
                    sel_reg = req_reg[2*c];       // Lower slot sets the row
                end
                else if (!found && req[2*c+1] && req_reg[2*c+1][1:0] == 2'(b))
                begin
                    found   = 1'b1;
                    win     = PW'(c);
                    sel_reg = req_reg[2*c+1];
                end
            end
            en = found && !(wb_en && wb_reg[1:0] == 2'(b));
            rd.rd_en[b]  = en;
            rd.rd_row[b] = sel_reg[4:2];
            rd.rd_tag[b] = '0;
            for (int t = 0; t < 2*`RF_NUM_OC; t++)
                if (en && req[t] && req_reg[t] == sel_reg)
                    rd.rd_tag[b][t] = 1'b1;       // Merge every slot naming this register
            grant     = grant | rd.rd_tag[b];
            winner[b] = win;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int b = 0; b < `RF_BANKS; b++)
        begin
            if (!rst_n)
                rr_ptr[b] <= '0;
            else if (rd.rd_en[b])
                rr_ptr[b] <= PW'((int'(winner[b]) + 1) % `RF_NUM_OC);
        end
    end

endmodule

// File: hdl/operand_collector.sv
`include "rf_config.svh"

module operand_collector #(
    parameter int index = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  rf_pkg::reg_idx_t             load_src0,
    input  rf_pkg::reg_idx_t             load_src1,
    input  rf_pkg::instr_id_t            load_id,
    input  logic                         retire,
    input  rf_pkg::oc_tag_t              grant,
    rf_read_if.oc                        rsp,
    output logic [1:0]                   req,
    output rf_pkg::reg_idx_t [1:0]       req_reg,
    output logic                         busy,
    output logic                         ready,
    output rf_pkg::instr_id_t            id,
    output rf_pkg::lane_data_t           op0,
    output rf_pkg::lane_data_t           op1
);

    logic [1:0]                   filled;
    logic [1:0]                   hit;
    logic [1:0]                   my_grant;
    rf_pkg::lane_data_t [1:0]     rsp_sel;

    assign my_grant = grant[2*index +: 2];
    assign ready    = busy && (&filled);

    // A merged read may fill both slots from one bank
    always_comb
    begin
        hit     = '0;
        rsp_sel = '0;
        for (int b = 0; b < `RF_BANKS; b++)
            for (int s = 0; s < 2; s++)
                if (rsp.rsp_valid[b] && rsp.rsp_tag[b][2*index+s])
                begin
                    hit[s]     = 1'b1;
                    rsp_sel[s] = rsp.rsp_data[b];
                end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy   <= 1'b0;
            req    <= '0;
            filled <= '0;
        end
        else if (load)
        begin
            busy   <= 1'b1;
            req    <= 2'b11;
            filled <= '0;
        end
        else if (retire)
            busy <= 1'b0;
        else
        begin
            req    <= req & ~my_grant;
            filled <= filled | hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            req_reg[0] <= load_src0;
            req_reg[1] <= load_src1;
            id         <= load_id;
        end
        if (hit[0])
            op0 <= rsp_sel[0];
        if (hit[1])
            op1 <= rsp_sel[1];
    end

endmodule

// File: hdl/oc_dispatch.sv
`include "rf_config.svh"

module oc_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [`RF_NUM_OC-1:0]                  busy,
    input  logic [`RF_NUM_OC-1:0]                  ready,
    input  rf_pkg::instr_id_t [`RF_NUM_OC-1:0]     id,
    input  rf_pkg::lane_data_t [`RF_NUM_OC-1:0]    op0,
    input  rf_pkg::lane_data_t [`RF_NUM_OC-1:0]    op1,
    output logic [`RF_NUM_OC-1:0]                  load,
    output logic [`RF_NUM_OC-1:0]                  retire,
    output logic                                   out_valid,
    output rf_pkg::instr_id_t                      out_id,
    output rf_pkg::lane_data_t                     out_op0,
    output rf_pkg::lane_data_t                     out_op1
);

    localparam int PW = $clog2(`RF_NUM_OC);

    logic          picked;
    logic [PW-1:0] pick;
    logic [PW-1:0] rr_ptr;

    assign in_ready = ~(&busy);

    always_comb
    begin
        logic found;
        int   c;

        found  = 1'b0;
        load   = '0;
        for (int k = 0; k < `RF_NUM_OC; k++)
            if (!found && !busy[k])
            begin
                found   = 1'b1;
                load[k] = in_valid;  // Lowest free collector takes it
            end
        picked = 1'b0;
        pick   = '0;
        retire = '0;
        for (int k = 0; k < `RF_NUM_OC; k++)
        begin
            c = (int'(rr_ptr) + k) % `RF_NUM_OC;
            if (!picked && ready[c])
            begin
                picked    = 1'b1;
                pick      = PW'(c);
                retire[c] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end
        else
        begin
            out_valid <= picked;
            if (picked)
                rr_ptr <= PW'((int'(pick) + 1) % `RF_NUM_OC);  // Alternate when both are ready
        end
    end

    always_ff @(posedge clk)
    begin
        if (picked)
        begin
            out_id  <= id[pick];
            out_op0 <= op0[pick];
            out_op1 <= op1[pick];
        end
    end

endmodule

// File: hdl/rf_subsystem.sv
`include "rf_config.svh"

module rf_subsystem (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  rf_pkg::reg_idx_t   in_src0,
    input  rf_pkg::reg_idx_t   in_src1,
    input  rf_pkg::instr_id_t  in_id,
    input  logic               wb_en,
    input  rf_pkg::reg_idx_t   wb_reg,
    input  rf_pkg::lane_mask_t wb_mask,
    input  rf_pkg::lane_data_t wb_data,
    output logic               out_valid,
    output rf_pkg::instr_id_t  out_id,
    output rf_pkg::lane_data_t out_op0,
    output rf_pkg::lane_data_t out_op1
);

    logic [2*`RF_NUM_OC-1:0]                req;
    rf_pkg::reg_idx_t [2*`RF_NUM_OC-1:0]    req_reg;
    rf_pkg::oc_tag_t                        grant;
    logic [`RF_NUM_OC-1:0]                  busy;
    logic [`RF_NUM_OC-1:0]                  ready;
    logic [`RF_NUM_OC-1:0]                  load;
    logic [`RF_NUM_OC-1:0]                  retire;
    rf_pkg::instr_id_t [`RF_NUM_OC-1:0]     oc_id;
    rf_pkg::lane_data_t [`RF_NUM_OC-1:0]    oc_op0;
    rf_pkg::lane_data_t [`RF_NUM_OC-1:0]    oc_op1;

    rf_read_if rd_bus ();

    register_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_mask (wb_mask),
        .wb_data (wb_data),
        .rd      (rd_bus.rf)
    );

    bank_arbiter u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .req_reg (req_reg),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .grant   (grant),
        .rd      (rd_bus.arb)
    );

    for (genvar c = 0; c < `RF_NUM_OC; c++)
    begin : g_oc
        operand_collector #(.index(c)) u_oc (
            .clk       (clk),
            .rst_n     (rst_n),
            .load      (load[c]),
            .load_src0 (in_src0),  // Only the loaded collector keeps it
            .load_src1 (in_src1),
            .load_id   (in_id),
            .retire    (retire[c]),
            .grant     (grant),
            .rsp       (rd_bus.oc),
            .req       (req[2*c +: 2]),
            .req_reg   (req_reg[2*c +: 2]),
            .busy      (busy[c]),
            .ready     (ready[c]),
            .id        (oc_id[c]),
            .op0       (oc_op0[c]),
            .op1       (oc_op1[c])
        );
    end

    oc_dispatch u_disp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .busy      (busy),
        .ready     (ready),
        .id        (oc_id),
        .op0       (oc_op0),
        .op1       (oc_op1),
        .load      (load),
        .retire    (retire),
        .out_valid (out_valid),
        .out_id    (out_id),
        .out_op0   (out_op0),
        .out_op1   (out_op1)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // Period of 20
    end

endmodule

// File: bench/rf_subsystem_sva.sv
`include "rf_config.svh"

module rf_subsystem_sva (
    input logic                            clk,
    input logic                            rst_n,
    input logic [2*`RF_NUM_OC-1:0]         req,
    input logic                            wb_en,
    input rf_pkg::reg_idx_t                wb_reg,
    input rf_pkg::oc_tag_t                 grant,
    input logic [`RF_BANKS-1:0]            rd_en,
    input rf_pkg::oc_tag_t [`RF_BANKS-1:0] rd_tag
);

    a_no_read_under_wb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> !rd_en[wb_reg[1:0]])
        else $error("Read granted on bank %0d while it is written", wb_reg[1:0]);

    a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
        (grant & ~req) == '0)
        else $error("Grant %h given to slots without a request %h", grant, req);

    // Disjoint bank tags have as many bits as their union
    a_grant_once: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(rd_tag) == $countones(grant))
        else $error("A slot was granted by more than one bank");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n && !$past(rst_n) |-> grant == '0)
        else $error("Grant %h raised during reset", grant);

endmodule

bind bank_arbiter rf_subsystem_sva u_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .wb_en  (wb_en),
    .wb_reg (wb_reg),
    .grant  (grant),
    .rd_en  (rd.rd_en),
    .rd_tag (rd.rd_tag)
);

// File: bench/rf_subsystem_tb.sv
`include "rf_config.svh"

module rf_subsystem_tb;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    rf_pkg::reg_idx_t   in_src0;
    rf_pkg::reg_idx_t   in_src1;
    rf_pkg::instr_id_t  in_id;
    logic               wb_en;
    rf_pkg::reg_idx_t   wb_reg;
    rf_pkg::lane_mask_t wb_mask;
    rf_pkg::lane_data_t wb_data;
    logic               out_valid;
    rf_pkg::instr_id_t  out_id;
    rf_pkg::lane_data_t out_op0;
    rf_pkg::lane_data_t out_op1;

    rf_pkg::lane_data_t model [32];
    rf_pkg::lane_data_t exp_op0 [256];  // Indexed by instruction id
    rf_pkg::lane_data_t exp_op1 [256];
    rf_pkg::reg_idx_t   exp_src0 [256];
    rf_pkg::reg_idx_t   exp_src1 [256];
    logic               pending [256];
    int                 n_pending;
    int                 issued;
    int                 completed;
    int                 errors;
    int                 cycles = 0;
    logic               checking;
    logic               saw_full;
    rf_pkg::instr_id_t  next_id;
    integer             seed;

    tb_clock u_clk (.clk(clk));

    rf_subsystem UUT (.*);

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > 40 * issued + 200)
        begin
            $display("Timeout after %0d cycles with %0d instructions outstanding",
                     cycles, n_pending);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_mismatch(string sig, rf_pkg::instr_id_t id,
                                   rf_pkg::lane_data_t exp, rf_pkg::lane_data_t got);
        $display("Error: %s for id %h expected %h got %h", sig, id, exp, got);
        errors++;
    endtask

    task automatic flag_problem(string what);
        $display("%s", what);
        errors++;
    endtask

    function automatic rf_pkg::lane_data_t fill_value(rf_pkg::reg_idx_t r, logic [7:0] salt);
        rf_pkg::lane_data_t v;
        for (int l = 0; l < `RF_LANES; l++)
            v[l*`RF_LANE_W +: `RF_LANE_W] = {salt, 3'b0, r, 8'(l), 8'(r) ^ 8'(l * 29)};
        return v;
    endfunction

    function automatic rf_pkg::lane_data_t random_value();
        rf_pkg::lane_data_t v;
        for (int l = 0; l < `RF_LANES; l++)
            v[l*`RF_LANE_W +: `RF_LANE_W] = $random(seed);
        return v;
    endfunction

    function automatic logic reg_in_use(rf_pkg::reg_idx_t r);
        for (int i = 0; i < 256; i++)
            if (pending[i] && (exp_src0[i] == r || exp_src1[i] == r))
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic check_outputs();
        if (out_valid === 1'b1)
        begin
            assert (pending[out_id] === 1'b1)
                else flag_problem($sformatf("Result for id %h was not expected", out_id));
            if (pending[out_id] === 1'b1)
            begin
                assert (out_op0 === exp_op0[out_id])
                    else report_mismatch("out_op0", out_id, exp_op0[out_id], out_op0);
                assert (out_op1 === exp_op1[out_id])
                    else report_mismatch("out_op1", out_id, exp_op1[out_id], out_op1);
                pending[out_id] = 1'b0;
                n_pending--;
                completed++;
            end
        end
        // Both collectors busy exactly when two instructions are outstanding
        assert (in_ready === (n_pending < 2))
            else flag_problem($sformatf("Error: in_ready expected %h got %h",
                                        n_pending < 2, in_ready));
    endtask

    task automatic tick();
        @(negedge clk);
        in_valid = 1'b0;
        wb_en    = 1'b0;
        if (checking)
            check_outputs();
    endtask

    task automatic write_register(rf_pkg::reg_idx_t r, rf_pkg::lane_mask_t m,
                                  rf_pkg::lane_data_t d);
        wb_en   = 1'b1;
        wb_reg  = r;
        wb_mask = m;
        wb_data = d;
        for (int l = 0; l < `RF_LANES; l++)
            if (m[l])
                model[r][l*`RF_LANE_W +: `RF_LANE_W] = d[l*`RF_LANE_W +: `RF_LANE_W];
    endtask

    // Expected operands are fixed when the instruction is accepted
    task automatic issue_instr(rf_pkg::reg_idx_t s0, rf_pkg::reg_idx_t s1);
        in_valid          = 1'b1;
        in_src0           = s0;
        in_src1           = s1;
        in_id             = next_id;
        exp_op0[next_id]  = model[s0];
        exp_op1[next_id]  = model[s1];
        exp_src0[next_id] = s0;
        exp_src1[next_id] = s1;
        pending[next_id]  = 1'b1;
        n_pending++;
        issued++;
        next_id++;
    endtask

    task automatic send(rf_pkg::reg_idx_t s0, rf_pkg::reg_idx_t s1);
        while (in_ready !== 1'b1)
        begin
            saw_full = 1'b1;
            tick();
        end
        issue_instr(s0, s1);
        tick();
    endtask

    task automatic drain();
        while (n_pending != 0)
            tick();
    endtask

    task automatic reset_state();
        assert (out_valid === 1'b0)
            else flag_problem($sformatf("Error: out_valid expected 0 got %h", out_valid));
        assert (in_ready === 1'b1)
            else flag_problem($sformatf("Error: in_ready expected 1 got %h", in_ready));
    endtask

    task automatic plain_reads();
        for (int r = 0; r < 32; r++)
        begin
            write_register(5'(r), '1, fill_value(5'(r), 8'hA5));
            tick();
        end
        for (int i = 0; i < 16; i++)
            send(5'(i * 3), 5'(31 - i * 5));
        drain();
    endtask

    task automatic lane_masks();
        write_register(5'd6, 8'h0F, fill_value(5'd6, 8'h3C));
        tick();
        write_register(5'd7, 8'hA0, fill_value(5'd7, 8'h3C));
        tick();
        send(5'd6, 5'd7);
        send(5'd7, 5'd22);
        drain();
        write_register(5'd6, 8'h81, fill_value(5'd6, 8'hC3));
        tick();
        send(5'd6, 5'd22);
        send(5'd6, 5'd6);
        drain();
    endtask

    task automatic bank_conflicts();
        send(5'd1, 5'd5);   // Both in bank 1 on rows 0 and 1
        send(5'd9, 5'd9);
        drain();
        send(5'd13, 5'd2);
        send(5'd13, 5'd13);
        send(5'd4, 5'd8);
        send(5'd8, 5'd4);
        drain();
    endtask

    task automatic back_pressure();
        saw_full = 1'b0;
        for (int i = 0; i < 12; i++)
            send(5'(i * 7), 5'(i * 11 + 3));
        drain();
        assert (saw_full === 1'b1)
            else flag_problem("in_ready never fell while both collectors were busy");
    endtask

    task automatic random_traffic();
        int               left;
        logic [31:0]      rnd;
        rf_pkg::reg_idx_t wr;

        left = 40;
        while (left > 0)
        begin
            rnd = $random(seed);
            wr  = rnd[4:0];
            if (rnd[6:5] == 2'b00 && !reg_in_use(wr))
                write_register(wr, rnd[14:7], random_value());
            if (rnd[15] && in_ready === 1'b1)
            begin
                issue_instr(rnd[20:16], rnd[25:21]);
                left--;
            end
            tick();
        end
        drain();
    endtask

    initial
    begin
        for (int i = 0; i < 256; i++)
            pending[i] = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_src0   = '0;
        in_src1   = '0;
        in_id     = '0;
        wb_en     = 1'b0;
        wb_reg    = '0;
        wb_mask   = '0;
        wb_data   = '0;
        n_pending = 0;
        issued    = 0;
        completed = 0;
        errors    = 0;
        checking  = 1'b0;
        saw_full  = 1'b0;
        next_id   = '0;
        seed      = 46633;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        checking = 1'b1;
        plain_reads();
        lane_masks();
        bank_conflicts();
        back_pressure();
        random_traffic();
        $display("Issued %0d, completed %0d, errors %0d", issued, completed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: rf_subsystem.f
+incdir+hdl
hdl/rf_pkg.sv
hdl/rf_read_if.sv
hdl/masked_bank.sv
hdl/register_file.sv
hdl/bank_arbiter.sv
hdl/operand_collector.sv
hdl/oc_dispatch.sv
hdl/rf_subsystem.sv
bench/tb_clock.sv
bench/rf_subsystem_sva.sv
bench/rf_subsystem_tb.sv

// File: Makefile
TOP := rf_subsystem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rf_subsystem.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Everything OK" sim.log

lint:
	verilator --lint-only --timing --assert -f rf_subsystem.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
